// File: rtl/motion_pkg.sv
// Motion core types
`default_nettype none

package motion_pkg;

  // Host word and datapath widths
  localparam int WORD_BITS     = 64;
  localparam int DDA_BITS      = 32;
  localparam int DURATION_BITS = 32;
  localparam int POSITION_BITS = 32;

  typedef logic [WORD_BITS-1:0] host_word_t;

  // Signed DDA increment or accumulator
  typedef logic signed [DDA_BITS-1:0] dda_word_t;

  // Move length counted in DDA ticks
  typedef logic [DURATION_BITS-1:0] duration_t;

  // Signed step count of one axis
  typedef logic signed [POSITION_BITS-1:0] position_t;

  typedef logic [7:0] divisor_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_load,
    seq_run
  } seq_state_t;

endpackage

`default_nettype wire

// File: rtl/command_pkg.sv
// Host command encodings
`default_nettype none

package command_pkg;

  // Top byte of the first word of a command
  typedef logic [7:0] header_t;

  typedef enum logic [7:0] {
    cmd_coordinated_step = 8'h01,
    cmd_motor_enable     = 8'h0a,
    cmd_clk_divisor      = 8'h20,
    cmd_channel_info     = 8'hfd,
    cmd_api_version      = 8'hfe
  } command_t;

  // Reported by the API version command
  // Devel, major, minor, patch from top byte down
  localparam logic [31:0] API_VERSION = 32'h0001_0000;

endpackage

`default_nettype wire

// File: rtl/tick_divider.sv
// DDA tick divider
`default_nettype none
`timescale 1ns/1ps

module tick_divider import motion_pkg::*; (
  input  wire      CLK,
  input  wire      resetn,
  input  divisor_t divisor,
  output logic     tick
);

  divisor_t count;

  // Period is divisor+1 clocks, new divisor picked up on reload
  always_ff @(posedge CLK) begin
    if (resetn) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (count == '0) begin
      count <= divisor;
      tick  <= 1'b1;
    end else begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/dda_axis.sv
// DDA step generator for one axis
`default_nettype none
`timescale 1ns/1ps

module dda_axis import motion_pkg::*; (
  input  wire       CLK,
  input  wire       resetn,
  input  wire       tick,
  input  wire       load_move,
  input  wire       executing,
  input  dda_word_t increment,
  input  dda_word_t increment_step,
  input  wire       dir,
  output logic      step,
  output position_t position
);

  logic [DDA_BITS-1:0] accumulator;
  dda_word_t           rate;
  logic [DDA_BITS:0]   sum;

  // Carry out of the unsigned add is the step request
  assign sum = {1'b0, accumulator} + {1'b0, rate};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accumulator <= '0;
      step        <= 1'b0;
      position    <= '0;
    end else begin
      step <= 1'b0;
      if (load_move) begin
        accumulator <= '0;
      end else if (executing && tick) begin
        accumulator <= sum[DDA_BITS-1:0];
        if (sum[DDA_BITS]) begin
          step     <= 1'b1;
          position <= dir ? position + position_t'(1) : position - position_t'(1);
        end
      end
    end
  end

  // Rate ramps by the increment step on every counted tick
  always_ff @(posedge CLK) begin
    if (load_move) begin
      rate <= increment;
    end else if (executing && tick) begin
      rate <= rate + increment_step;
    end
  end

endmodule

`default_nettype wire

// File: rtl/move_sequencer.sv
// Move buffer sequencer
`default_nettype none
`timescale 1ns/1ps

module move_sequencer import motion_pkg::*; #(
  parameter int BUFFER_SIZE = 2,
  localparam int INDEX_BITS = $clog2(BUFFER_SIZE)
) (
  input  wire                    CLK,
  input  wire                    resetn,
  input  wire                    tick,
  input  wire  [BUFFER_SIZE-1:0] slot_ready,
  input  duration_t              move_duration,
  output logic [INDEX_BITS-1:0]  read_index,
  output logic                   load_move,
  output logic                   executing,
  output logic                   move_done,
  output logic                   buffer_dtr
);

  seq_state_t             state;
  duration_t              remaining;
  logic [BUFFER_SIZE-1:0] slot_done;
  logic [BUFFER_SIZE-1:0] ready_q;
  logic [INDEX_BITS-1:0]  write_index;
  logic                   slot_pending;

  // A slot holds a move while its ready and done toggles differ
  assign slot_pending = slot_ready[read_index] != slot_done[read_index];

  assign load_move = (state == seq_load);
  assign executing = (state == seq_run) && (remaining != '0);
  assign move_done = (state == seq_run) && (remaining == '0);

  // Delayed ready copy keeps the free flag aligned with the write index
  assign buffer_dtr = ready_q[write_index] == slot_done[write_index];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state       <= seq_idle;
      remaining   <= '0;
      slot_done   <= '0;
      ready_q     <= '0;
      read_index  <= '0;
      write_index <= '0;
    end else begin
      ready_q <= slot_ready;

      // Follow the decoder's write index from its ready toggles
      if (ready_q[write_index] != slot_ready[write_index]) begin
        write_index <= write_index + 1'b1;
      end

      case (state)
        seq_idle: begin
          if (slot_pending) begin
            state <= seq_load;
          end
        end
        seq_load: begin
          remaining <= move_duration;
          state     <= seq_run;
        end
        seq_run: begin
          if (remaining == '0) begin
            slot_done[read_index] <= ~slot_done[read_index];
            read_index            <= read_index + 1'b1;
            state                 <= seq_idle;
          end else if (tick) begin
            remaining <= remaining - 1'b1;
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/command_decoder.sv
// Host command decoder and move buffer
`default_nettype none
`timescale 1ns/1ps

module command_decoder import motion_pkg::*; import command_pkg::*; #(
  parameter int NUM_MOTORS      = 2,
  parameter int BUFFER_SIZE     = 2,
  parameter int DEFAULT_DIVISOR = 4,
  localparam int INDEX_BITS     = $clog2(BUFFER_SIZE)
) (
  input  wire                        CLK,
  input  wire                        resetn,
  input  host_word_t                 word_data,
  input  wire                        word_received,
  input  wire [INDEX_BITS-1:0]       read_index,
  input  position_t [NUM_MOTORS-1:0] positions,
  output host_word_t                 word_send_data,
  output logic [NUM_MOTORS-1:0]      enable,
  output divisor_t                   divisor,
  output logic [BUFFER_SIZE-1:0]     slot_ready,
  output duration_t                  move_duration,
  output logic [NUM_MOTORS-1:0]      move_dir,
  output dda_word_t [NUM_MOTORS-1:0] increments,
  output dda_word_t [NUM_MOTORS-1:0] increment_steps
);

  // Header, duration, then increment and increment step per motor
  localparam logic [7:0] LAST_WORD = 8'(2 * NUM_MOTORS + 1);

  logic                  word_received_q;
  logic                  word_taken;
  header_t               word_header;
  header_t               message_header;
  logic [7:0]            word_count;
  logic                  awaiting_more;
  logic [INDEX_BITS-1:0] write_index;
  host_word_t            reply;

  // Move buffer slots
  logic [NUM_MOTORS-1:0]      slot_dir [BUFFER_SIZE];
  duration_t                  slot_duration [BUFFER_SIZE];
  dda_word_t [NUM_MOTORS-1:0] slot_increment [BUFFER_SIZE];
  dda_word_t [NUM_MOTORS-1:0] slot_increment_step [BUFFER_SIZE];

  // Positions captured on the coordinated step header
  position_t [NUM_MOTORS-1:0] snapshot;

  assign word_taken    = word_received && !word_received_q;
  assign word_header   = word_data[WORD_BITS-1 -: 8];
  assign awaiting_more = (message_header == cmd_coordinated_step) ||
                         (message_header == cmd_api_version);

  // Slot selected by the sequencer
  assign move_duration   = slot_duration[read_index];
  assign move_dir        = slot_dir[read_index];
  assign increments      = slot_increment[read_index];
  assign increment_steps = slot_increment_step[read_index];

  always_comb begin
    reply = '0;
    if (!awaiting_more) begin
      case (word_header)
        cmd_api_version: reply[31:0] = API_VERSION;
        cmd_channel_info: begin
          reply[7:0]  = 8'(NUM_MOTORS);
          reply[15:8] = 8'(POSITION_BITS);
        end
        default: ;
      endcase
    end else if (message_header == cmd_coordinated_step) begin
      // Duration word returns motor 0, each increment step word the next motor
      for (int m = 0; m < NUM_MOTORS; m++) begin
        if (word_count == 8'(2 * m + 1)) begin
          reply[POSITION_BITS-1:0] = snapshot[m];
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      word_send_data  <= '0;
      message_header  <= '0;
      word_count      <= '0;
      write_index     <= '0;
      slot_ready      <= '0;
      enable          <= '0;
      divisor         <= divisor_t'(DEFAULT_DIVISOR);
      for (int s = 0; s < BUFFER_SIZE; s++) begin
        slot_dir[s] <= '0;
      end
    end else begin
      word_received_q <= word_received;
      if (word_taken) begin
        word_send_data <= reply;
        if (!awaiting_more) begin
          message_header <= word_header;
          word_count     <= 8'd1;
          case (word_header)
            cmd_coordinated_step: slot_dir[write_index] <= word_data[NUM_MOTORS-1:0];
            cmd_motor_enable:     enable <= word_data[NUM_MOTORS-1:0];
            cmd_clk_divisor:      divisor <= word_data[7:0];
            default: ;
          endcase
        end else if (message_header != cmd_coordinated_step) begin
          // Trailing word of a two word command
          message_header <= '0;
          word_count     <= '0;
        end else if (word_count == LAST_WORD) begin
          slot_ready[write_index] <= ~slot_ready[write_index];
          write_index             <= write_index + 1'b1;
          message_header          <= '0;
          word_count              <= '0;
        end else begin
          word_count <= word_count + 8'd1;
        end
      end
    end
  end

  // Move parameters and position snapshot
  always_ff @(posedge CLK) begin
    if (word_taken) begin
      if (!awaiting_more && word_header == cmd_coordinated_step) begin
        snapshot <= positions;
      end
      if (message_header == cmd_coordinated_step) begin
        if (word_count == 8'd1) begin
          slot_duration[write_index] <= word_data[DURATION_BITS-1:0];
        end
        for (int m = 0; m < NUM_MOTORS; m++) begin
          if (word_count == 8'(2 * m + 2)) begin
            slot_increment[write_index][m] <= word_data[DDA_BITS-1:0];
          end
          if (word_count == 8'(2 * m + 3)) begin
            slot_increment_step[write_index][m] <= word_data[DDA_BITS-1:0];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/motion_controller.sv
// Motion controller top
`default_nettype none
`timescale 1ns/1ps

module motion_controller import motion_pkg::*; #(
  parameter int NUM_MOTORS      = 2,
  parameter int BUFFER_SIZE     = 2,
  parameter int DEFAULT_DIVISOR = 4
) (
  input  wire                   CLK,
  input  wire                   resetn,
  input  host_word_t            word_data,
  input  wire                   word_received,
  output host_word_t            word_send_data,
  output wire  [NUM_MOTORS-1:0] step,
  output wire  [NUM_MOTORS-1:0] dir,
  output logic [NUM_MOTORS-1:0] enable,
  output logic                  buffer_dtr,
  output logic                  move_done
);

  localparam int INDEX_BITS = $clog2(BUFFER_SIZE);

  divisor_t                   divisor;
  logic                       tick;
  logic [BUFFER_SIZE-1:0]     slot_ready;
  logic [INDEX_BITS-1:0]      read_index;
  duration_t                  move_duration;
  dda_word_t [NUM_MOTORS-1:0] increments;
  dda_word_t [NUM_MOTORS-1:0] increment_steps;
  logic                       load_move;
  logic                       executing;
  wire position_t [NUM_MOTORS-1:0] positions;

  command_decoder #(
    .NUM_MOTORS      (NUM_MOTORS),
    .BUFFER_SIZE     (BUFFER_SIZE),
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR)
  ) u_decoder (
    .CLK, .resetn, .word_data, .word_received, .read_index, .positions,
    .word_send_data, .enable, .divisor, .slot_ready, .move_duration,
    .move_dir (dir),
    .increments, .increment_steps
  );

  tick_divider u_divider (
    .CLK, .resetn, .divisor, .tick
  );

  move_sequencer #(
    .BUFFER_SIZE (BUFFER_SIZE)
  ) u_sequencer (
    .CLK, .resetn, .tick, .slot_ready, .move_duration,
    .read_index, .load_move, .executing, .move_done, .buffer_dtr
  );

  // One DDA step generator per motor
  for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_axis
    dda_axis u_axis (
      .CLK, .resetn, .tick, .load_move, .executing,
      .increment      (increments[m]),
      .increment_step (increment_steps[m]),
      .dir            (dir[m]),
      .step           (step[m]),
      .position       (positions[m])
    );
  end

endmodule

`default_nettype wire

// File: verification/motion_controller_checker.sv
// Motion controller assertions
`default_nettype none
`timescale 1ns/1ps

module motion_controller_checker import motion_pkg::*; import command_pkg::*; #(
  parameter int NUM_MOTORS = 2
) (
  input wire                  CLK,
  input wire                  resetn,
  input host_word_t           word_data,
  input wire                  word_received,
  input wire [NUM_MOTORS-1:0] step,
  input wire [NUM_MOTORS-1:0] dir,
  input wire                  buffer_dtr,
  input wire                  move_done,
  input wire                  executing
);

  logic        word_q;
  logic        word_edge;
  header_t     word_header;
  logic [7:0]  words_left;
  logic        upload_start;
  int unsigned failures = 0;

  assign word_edge   = word_received && !word_q;
  assign word_header = word_data[WORD_BITS-1 -: 8];

  // First word of a coordinated step command
  assign upload_start = word_edge && (words_left == '0) &&
                        (word_header == cmd_coordinated_step);

  // Words still owed to the command in progress
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_q     <= 1'b0;
      words_left <= '0;
    end else begin
      word_q <= word_received;
      if (word_edge) begin
        if (words_left != '0) begin
          words_left <= words_left - 8'd1;
        end else if (word_header == cmd_coordinated_step) begin
          words_left <= 8'(2 * NUM_MOTORS + 1);
        end else if (word_header == cmd_api_version) begin
          words_left <= 8'd1;
        end
      end
    end
  end

  assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else begin
      failures++;
      $error("move_done high for more than one cycle");
    end

  // Registered step follows a cycle spent executing
  assert property (@(posedge CLK) disable iff (resetn) (step != '0) |-> $past(executing))
    else begin
      failures++;
      $error("step pulse outside of a move");
    end

  assert property (@(posedge CLK) disable iff (resetn) upload_start |-> buffer_dtr)
    else begin
      failures++;
      $error("upload started while buffer_dtr was low");
    end

  assert property (@(posedge CLK) disable iff (resetn)
                   executing && $past(executing) |-> $stable(dir))
    else begin
      failures++;
      $error("dir changed during a move");
    end

endmodule

bind motion_controller motion_controller_checker #(.NUM_MOTORS(NUM_MOTORS)) u_checker (
  .CLK           (CLK),
  .resetn        (resetn),
  .word_data     (word_data),
  .word_received (word_received),
  .step          (step),
  .dir           (dir),
  .buffer_dtr    (buffer_dtr),
  .move_done     (move_done),
  .executing     (executing)
);

`default_nettype wire

// File: verification/tb_motion_controller.sv
// Motion controller testbench
`default_nettype none
`timescale 1ns/1ps

module tb_motion_controller import motion_pkg::*; import command_pkg::*; ();

  localparam int NUM_MOTORS      = 2;
  localparam int BUFFER_SIZE     = 2;
  localparam int DEFAULT_DIVISOR = 4;
  localparam int SLOW_DIVISOR    = 9;
  // Summed durations of every move below
  localparam int MOVE_TICKS      = 100 + 80 + 60 + 50 + 40;
  localparam int WORD_CYCLES     = 4 * 64;
  localparam int TIMEOUT_CYCLES  = 2 * MOVE_TICKS * (SLOW_DIVISOR + 1) + WORD_CYCLES + 20;

  logic                  CLK;
  logic                  resetn;
  host_word_t            word_data;
  logic                  word_received;
  host_word_t            word_send_data;
  logic [NUM_MOTORS-1:0] step;
  logic [NUM_MOTORS-1:0] dir;
  logic [NUM_MOTORS-1:0] enable;
  logic                  buffer_dtr;
  logic                  move_done;

  int unsigned           cycles = 0;
  int                    errors;
  int                    test_errors;
  int                    tests;
  int                    failed_tests;
  integer                seed;
  int                    run_steps0;
  int                    run_steps1;
  int                    steps0_q [$];
  int                    steps1_q [$];
  int                    done_cycle_q [$];
  logic [NUM_MOTORS-1:0] done_dir_q [$];
  // Expected axis positions
  int                    pos0;
  int                    pos1;
  int                    last_word_cycle;

  motion_controller #(
    .NUM_MOTORS      (NUM_MOTORS),
    .BUFFER_SIZE     (BUFFER_SIZE),
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR)
  ) u_dut (
    .CLK            (CLK),
    .resetn         (resetn),
    .word_data      (word_data),
    .word_received  (word_received),
    .word_send_data (word_send_data),
    .step           (step),
    .dir            (dir),
    .enable         (enable),
    .buffer_dtr     (buffer_dtr),
    .move_done      (move_done)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  // Per move step totals sampled mid cycle
  always @(negedge CLK) begin
    if (!resetn) begin
      run_steps0 = run_steps0 + int'(step[0]);
      run_steps1 = run_steps1 + int'(step[1]);
      if (move_done) begin
        steps0_q.push_back(run_steps0);
        steps1_q.push_back(run_steps1);
        done_cycle_q.push_back(int'(cycles));
        done_dir_q.push_back(dir);
        run_steps0 = 0;
        run_steps1 = 0;
      end
    end
  end

  task automatic check_value(input string what, input host_word_t got,
                             input host_word_t expected);
    if (got !== expected) begin
      errors++;
      test_errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Two cycles high and two low with the reply read at the end
  task automatic send_word(input host_word_t value, output host_word_t reply);
    word_data     = value;
    word_received = 1'b1;
    repeat (2) @(negedge CLK);
    word_received = 1'b0;
    repeat (2) @(negedge CLK);
    reply = word_send_data;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("%s: %s", name, (test_errors == 0) ? "passed" : "failed");
    test_errors = 0;
  endtask

  // Carries out of a 32-bit accumulator after duration additions
  function automatic int expected_steps(input logic [31:0] duration, input logic [31:0] inc);
    logic [63:0] product;
    product = {32'd0, duration} * {32'd0, inc};
    return int'(product[63:32]);
  endfunction

  task automatic upload_move(input logic [NUM_MOTORS-1:0] mask, input logic [31:0] duration,
                             input logic [31:0] inc0, input logic [31:0] inc1,
                             input bit check_snap);
    host_word_t words [6];
    host_word_t expected [6];
    host_word_t reply;
    while (!buffer_dtr) @(negedge CLK);
    words[0] = {8'h01, 54'd0, mask};
    words[1] = {32'd0, duration};
    words[2] = {32'd0, inc0};
    words[3] = '0;
    words[4] = {32'd0, inc1};
    words[5] = '0;
    foreach (expected[i]) expected[i] = '0;
    // Duration word returns motor 0 and the first increment step word motor 1
    expected[1] = {32'd0, 32'(pos0)};
    expected[3] = {32'd0, 32'(pos1)};
    for (int i = 0; i < 6; i++) begin
      if (i == 5) begin
        last_word_cycle = int'(cycles);
      end
      send_word(words[i], reply);
      if (check_snap || (i != 1 && i != 3)) begin
        check_value($sformatf("upload word %0d reply", i), reply, expected[i]);
      end
    end
  endtask

  task automatic check_move(input logic [NUM_MOTORS-1:0] mask, input logic [31:0] duration,
                            input logic [31:0] inc0, input logic [31:0] inc1,
                            output int done_cycle);
    int exp0;
    int exp1;
    exp0 = expected_steps(duration, inc0);
    exp1 = expected_steps(duration, inc1);
    while (steps0_q.size() == 0) @(negedge CLK);
    check_value("motor 0 steps", 64'(steps0_q.pop_front()), 64'(exp0));
    check_value("motor 1 steps", 64'(steps1_q.pop_front()), 64'(exp1));
    check_value("dir at move_done", 64'(done_dir_q.pop_front()), 64'(mask));
    done_cycle = done_cycle_q.pop_front();
    pos0 = mask[0] ? pos0 + exp0 : pos0 - exp0;
    pos1 = mask[1] ? pos1 + exp1 : pos1 - exp1;
  endtask

  initial begin
    host_word_t  reply;
    logic [31:0] inc [8];
    int          done_cycle;
    int          min_cycles;
    CLK           = 1'b0;
    resetn        = 1'b1;
    word_data     = '0;
    word_received = 1'b0;
    seed          = 32'h9c18_4608;
    errors        = 0;
    test_errors   = 0;
    tests         = 0;
    failed_tests  = 0;
    pos0          = 0;
    pos1          = 0;
    run_steps0    = 0;
    run_steps1    = 0;
    for (int i = 0; i < 8; i++) begin
      inc[i] = $random(seed);
    end
    repeat (10) @(negedge CLK);
    resetn = 1'b0;
    @(negedge CLK);

    send_word({8'hfe, 56'd0}, reply);
    check_value("API version reply", reply, {32'd0, API_VERSION});
    send_word(64'd0, reply);
    check_value("API version trailing reply", reply, 64'd0);
    send_word({8'hfd, 56'd0}, reply);
    check_value("channel info reply", reply, {48'd0, 8'd32, 8'(NUM_MOTORS)});
    send_word({8'h55, 56'h1234}, reply);
    check_value("unknown header reply", reply, 64'd0);
    end_test("version and info");

    send_word({8'h0a, 54'd0, 2'b11}, reply);
    check_value("enable mask", 64'(enable), 64'(2'b11));
    send_word({8'h0a, 54'd0, 2'b01}, reply);
    check_value("enable mask rewrite", 64'(enable), 64'(2'b01));
    end_test("motor enable");

    upload_move(2'b01, 100, inc[0], inc[1], 1'b1);
    check_move(2'b01, 100, inc[0], inc[1], done_cycle);
    repeat (20) @(negedge CLK);
    check_value("extra move_done count", 64'(steps0_q.size()), 64'd0);
    end_test("single move");

    upload_move(2'b10, 80, inc[2], inc[3], 1'b1);
    // No snapshot check while the first move is still stepping
    upload_move(2'b11, 60, inc[4], inc[5], 1'b0);
    check_value("buffer_dtr with both slots busy", 64'(buffer_dtr), 64'd0);
    check_move(2'b10, 80, inc[2], inc[3], done_cycle);
    repeat (2) @(negedge CLK);
    check_value("buffer_dtr after first move", 64'(buffer_dtr), 64'd1);
    check_move(2'b11, 60, inc[4], inc[5], done_cycle);
    end_test("two buffered moves");

    upload_move(2'b00, 50, inc[6], inc[7], 1'b1);
    check_move(2'b00, 50, inc[6], inc[7], done_cycle);
    send_word({8'h20, 48'd0, 8'(SLOW_DIVISOR)}, reply);
    upload_move(2'b11, 40, inc[0], inc[3], 1'b1);
    check_move(2'b11, 40, inc[0], inc[3], done_cycle);
    // Forty ticks spaced by the new divisor period
    min_cycles = (40 - 1) * (SLOW_DIVISOR + 1) + 1;
    if (done_cycle - last_word_cycle < min_cycles) begin
      errors++;
      test_errors++;
      $display("** Error at %0t: move_done after %0d cycles, expected at least %0d",
               $time, done_cycle - last_word_cycle, min_cycles);
    end
    end_test("positions and divisor");

    errors = errors + int'(u_dut.u_checker.failures);
    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
rtl/motion_pkg.sv
rtl/command_pkg.sv
rtl/tick_divider.sv
rtl/dda_axis.sv
rtl/move_sequencer.sv
rtl/command_decoder.sv
rtl/motion_controller.sv
verification/motion_controller_checker.sv
verification/tb_motion_controller.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_motion_controller
FILELIST  := sim.f
BUILD_DIR := obj_dir
PASS      := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD_DIR)
